// ==== vlog.f ====
+incdir+testbench
hw/ooo_pkg.sv
hw/dispatch_buffer.sv
hw/reservation_station.sv
hw/exec_unit.sv
hw/exec_cluster.sv
testbench/tb_exec_cluster.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_exec_cluster \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_exec_cluster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1

// ==== testbench/tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

// expected value per tag, the latest producer's result or the value it already returned
logic [xlen-1:0] tag_val   [2**rob_tag_len];
logic            in_flight [2**rob_tag_len]; // dispatched and not yet seen on the result stream

// integer functions as the instruction set defines them
function automatic logic [xlen-1:0] alu_ref(input alu_func_e f, input logic [xlen-1:0] a,
                                            input logic [xlen-1:0] b);
    logic [2*xlen-1:0] prod;
    logic [4:0]        shamt;
    prod  = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b}; // full product, only the low half is kept
    shamt = b[4:0];                                // shifts use the low 5 bits of b
    case (f)
        alu_add: alu_ref = a + b;
        alu_sub: alu_ref = a - b;
        alu_and: alu_ref = a & b;
        alu_or:  alu_ref = a | b;
        alu_xor: alu_ref = a ^ b;
        alu_sll: alu_ref = a << shamt;
        alu_srl: alu_ref = a >> shamt;
        alu_mul: alu_ref = prod[xlen-1:0];
        default: alu_ref = '0;
    endcase
endfunction

// how the source presents one operand, and the value the result must be computed from
// a negative src stands for an immediate that is ready and carries imm
function automatic void resolve_operand(input int src, input logic [xlen-1:0] imm,
                                        output logic rdy, output logic [rob_tag_len-1:0] tag,
                                        output logic [xlen-1:0] sent,
                                        output logic [xlen-1:0] exp_v);
    if (src < 0) begin
        rdy   = 1'b1;
        tag   = '0;
        sent  = imm;
        exp_v = imm;
    end else begin
        tag   = rob_tag_len'(src);
        rdy   = !in_flight[tag]; // a producer still in flight leaves the operand pending
        exp_v = tag_val[tag];
        sent  = rdy ? exp_v : ~exp_v; // pending operands carry a stale value
    end
endfunction

`endif

// ==== testbench/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster;
    import ooo_pkg::*;

    localparam int clk_period  = 4;
    localparam int total_insns = 16 + 8 + 12 + 13 + 200; // all five tests together
    localparam int watchdog_ns = (total_insns * 40 + 3) * clk_period;

    logic                   clk, reset, load;
    alu_func_e              func;
    logic [rob_tag_len-1:0] t1, t2, dst;
    logic                   ready1, ready2;
    logic [xlen-1:0]        v1, v2;
    logic                   full, result_valid;
    logic [rob_tag_len-1:0] result_tag;
    logic [xlen-1:0]        result_value;

    `include "tb_model.svh"

    int                     seed = 32'h21ed_74e2;
    string                  test_name;
    logic                   check_order;  // result tags must follow the load order
    logic                   full_seen;
    logic [rob_tag_len-1:0] order_q [$];
    logic [rob_tag_len-1:0] next_tag;     // round robin start for picking a free tag
    int                     dispatched, retired;

    exec_cluster exec_cluster_i (
        .clk, .reset, .load, .func, .t1, .t2, .dst, .ready1, .ready2, .v1, .v2,
        .full, .result_valid, .result_tag, .result_value
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic bit find_free_tag(output logic [rob_tag_len-1:0] d);
        logic [rob_tag_len-1:0] cand;
        find_free_tag = 1'b0;
        d = '0;
        for (int k = 0; k < 2**rob_tag_len; k++) begin
            cand = next_tag + rob_tag_len'(k);
            if (!find_free_tag && !in_flight[cand]) begin
                d = cand;
                find_free_tag = 1'b1;
            end
        end
    endfunction

    function automatic int count_in_flight();
        int n;
        n = 0;
        for (int k = 0; k < 2**rob_tag_len; k++) begin
            n += int'(in_flight[k]);
        end
        return n;
    endfunction

    // one load, held back while the buffer is full or no tag is free
    task automatic send_insn(input alu_func_e f, input int s1, input int s2,
                             output logic [rob_tag_len-1:0] d);
        logic                   rdy_a, rdy_b;
        logic [rob_tag_len-1:0] tag_a, tag_b;
        logic [xlen-1:0]        sent_a, sent_b, exp_a, exp_b, imm_a, imm_b;
        imm_a = $random(seed);
        imm_b = $random(seed);
        @(posedge clk);
        #1;
        while (full || !find_free_tag(d)) begin
            load = 1'b0;
            @(posedge clk);
            #1;
        end
        // operands are resolved now, as the producers' state may have changed while waiting
        resolve_operand(s1, imm_a, rdy_a, tag_a, sent_a, exp_a);
        resolve_operand(s2, imm_b, rdy_b, tag_b, sent_b, exp_b);
        load   = 1'b1;
        func   = f;
        t1     = tag_a;
        t2     = tag_b;
        dst    = d;
        ready1 = rdy_a;
        ready2 = rdy_b;
        v1     = sent_a;
        v2     = sent_b;
        tag_val[d]   = alu_ref(f, exp_a, exp_b);
        in_flight[d] = 1'b1;
        next_tag     = d + 1'b1;
        dispatched++;
        if (check_order) order_q.push_back(d);
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
        load = 1'b0; // the last load was taken on the edge above
        while (count_in_flight() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // scoreboard, checks every result against the table and retires its tag
    always @(posedge clk) begin
        if (!reset) begin
            assert (!(load && full)) else begin
                $display("a load was driven while the dispatch buffer was full");
                $display("Result: FAILED");
                $fatal(1, "load while full");
            end
            if (full) full_seen = 1'b1;
            if (result_valid) begin
                assert (in_flight[result_tag]) else begin
                    $display("result on tag %0d, which has no instruction in flight", result_tag);
                    $display("Result: FAILED");
                    $fatal(1, "stray result");
                end
                if (check_order) begin
                    assert (order_q.size() != 0 && order_q[0] == result_tag) else begin
                        $display("FAILED %s: expected tag %0d actual tag %0d",
                                 test_name, order_q[0], result_tag);
                        $display("Result: FAILED");
                        $fatal(1, "out of order");
                    end
                    void'(order_q.pop_front());
                end
                assert (result_value === tag_val[result_tag]) else begin
                    $display("FAILED %s: tag %0d expected %h actual %h",
                             test_name, result_tag, tag_val[result_tag], result_value);
                    $display("Result: FAILED");
                    $fatal(1, "wrong result");
                end
                in_flight[result_tag] = 1'b0;
                retired++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired in %s, the cluster stopped producing results", test_name);
        $display("Result: FAILED");
        $fatal(1, "hang");
    end

    initial begin
        logic [rob_tag_len-1:0] a, b, d;
        logic [rob_tag_len-1:0] recent [4]; // last few destinations, sources for the random mix
        int                     rnd;
        clk = 1'b0;
        reset = 1'b1;
        load = 1'b0;
        func = alu_add;
        {t1, t2, dst, ready1, ready2, v1, v2} = '0;
        {check_order, full_seen, next_tag, dispatched, retired} = '0;
        test_name = "reset";
        for (int k = 0; k < 2**rob_tag_len; k++) begin
            tag_val[k]   = xlen'(k + 1) * 32'h9e37_79b9; // initial register contents
            in_flight[k] = 1'b0;
        end
        for (int k = 0; k < 4; k++) recent[k] = rob_tag_len'(k);
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "alu_ops";
        for (int k = 0; k < 16; k++) send_insn(alu_func_e'(k % 8), -1, -1, d);
        drain();

        test_name = "age_order";
        check_order = 1'b1;
        for (int k = 0; k < 8; k++) send_insn(alu_func_e'(k), -1, -1, d);
        drain();
        check_order = 1'b0;

        // each step consumes the previous destination while it is still pending
        test_name = "dep_chains";
        for (int k = 0; k < 4; k++) begin
            send_insn(alu_add, -1, -1, a);
            send_insn(alu_mul, a, -1, b);
            send_insn(alu_sub, b, a, d);
        end
        drain();

        test_name = "back_pressure";
        full_seen = 1'b0;
        send_insn(alu_mul, -1, -1, a);
        for (int k = 0; k < 12; k++) begin
            send_insn((k % 3 == 0) ? alu_mul : alu_func_e'(k % 7), a, -1, d);
        end
        drain();
        assert (full_seen) else begin
            $display("the dispatch buffer never reported full under back-pressure");
            $display("Result: FAILED");
            $fatal(1, "no back-pressure");
        end

        test_name = "random_mix";
        for (int k = 0; k < 200; k++) begin
            rnd = $random(seed);
            send_insn(alu_func_e'(rnd[2:0]), rnd[3] ? int'(recent[rnd[5:4]]) : -1,
                      rnd[6] ? int'(recent[rnd[8:7]]) : -1, d);
            recent[k % 4] = d;
        end
        drain();

        if (count_in_flight() == 0 && retired == dispatched) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d of %0d instructions never returned a result",
                     dispatched - retired, dispatched);
            $display("Result: FAILED");
            $fatal(1, "unretired tags");
        end
    end

endmodule

// ==== hw/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load,
    input  ooo_pkg::alu_func_e                 func,
    input  logic [ooo_pkg::rob_tag_len-1:0]    t1, t2, dst,
    input  logic                               ready1, ready2,
    input  logic [ooo_pkg::xlen-1:0]           v1, v2,
    output logic                               full,
    output logic                               result_valid,
    output logic [ooo_pkg::rob_tag_len-1:0]    result_tag,
    output logic [ooo_pkg::xlen-1:0]           result_value
);
    import ooo_pkg::*;

    // dispatch buffer to station
    logic                   rs_load, rs_full;
    alu_func_e              rs_func;
    logic [rob_tag_len-1:0] rs_t1, rs_t2, rs_dst;
    logic                   rs_ready1, rs_ready2;
    logic [xlen-1:0]        rs_v1, rs_v2;

    // station to execution unit
    logic                   insn_ready, issue;
    alu_func_e              func_out;
    logic [xlen-1:0]        v1_out, v2_out;
    logic [rob_tag_len-1:0] dst_tag;

    // the result stream doubles as the wakeup broadcast
    dispatch_buffer dispatch_buffer_i (
        .clk, .reset, .load, .func, .t1, .t2, .dst, .ready1, .ready2, .v1, .v2,
        .wakeup(result_valid), .wakeup_tag(result_tag), .wakeup_value(result_value),
        .rs_full, .full, .rs_load, .rs_func, .rs_t1, .rs_t2, .rs_dst,
        .rs_ready1, .rs_ready2, .rs_v1, .rs_v2
    );

    reservation_station reservation_station_i (
        .clk, .reset, .load(rs_load), .func(rs_func), .t1(rs_t1), .t2(rs_t2),
        .dst(rs_dst), .ready1(rs_ready1), .ready2(rs_ready2), .v1(rs_v1), .v2(rs_v2),
        .issue, .wakeup(result_valid), .wakeup_tag(result_tag),
        .wakeup_value(result_value), .insn_ready, .is_full(rs_full),
        .func_out, .v1_out, .v2_out, .dst_tag
    );

    exec_unit exec_unit_i (
        .clk, .reset, .insn_ready, .func_out, .v1_out, .v2_out, .dst_tag, .issue,
        .wakeup(result_valid), .wakeup_tag(result_tag), .wakeup_value(result_value)
    );

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               insn_ready,
    input  ooo_pkg::alu_func_e                 func_out,
    input  logic [ooo_pkg::xlen-1:0]           v1_out, v2_out,
    input  logic [ooo_pkg::rob_tag_len-1:0]    dst_tag,
    output logic                               issue,
    output logic                               wakeup,
    output logic [ooo_pkg::rob_tag_len-1:0]    wakeup_tag,
    output logic [ooo_pkg::xlen-1:0]           wakeup_value
);
    import ooo_pkg::*;

    ex_state_e             state;
    logic                  pending;   // issued last cycle, station outputs are valid now
    logic [ex_cnt_len-1:0] cnt;       // execute cycles left after the current one
    alu_func_e             op_func;
    logic [xlen-1:0]       op_a, op_b;

    // the last busy cycle broadcasts and frees the unit in the same cycle
    assign wakeup = (state == ex_busy) && (cnt == '0);
    assign issue  = insn_ready && !pending && ((state == ex_idle) || wakeup);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ex_idle;
            pending <= 1'b0;
            cnt     <= '0;
        end else begin
            pending <= issue;
            if (pending) begin
                state <= ex_busy;
                cnt   <= (func_out == alu_mul) ? ex_cnt_len'(mul_latency - 1) : '0;
            end else if (wakeup) begin
                state <= ex_idle;
            end else if (state == ex_busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // operand and destination registers, loaded once per instruction
    always_ff @(posedge clk) begin
        if (pending) begin
            op_func    <= func_out;
            op_a       <= v1_out;
            op_b       <= v2_out;
            wakeup_tag <= dst_tag;
        end
    end

    always_comb begin
        case (op_func)
            alu_add: wakeup_value = op_a + op_b;
            alu_sub: wakeup_value = op_a - op_b;
            alu_and: wakeup_value = op_a & op_b;
            alu_or:  wakeup_value = op_a | op_b;
            alu_xor: wakeup_value = op_a ^ op_b;
            alu_sll: wakeup_value = op_a << op_b[4:0]; // shift amount is the low 5 bits
            alu_srl: wakeup_value = op_a >> op_b[4:0];
            alu_mul: wakeup_value = op_a * op_b;       // low half of the product
            default: wakeup_value = '0;
        endcase
    end

    // each issue ends in a broadcast from the busy state, 2 to mul_latency+1 cycles later
    a_issue_then_wakeup: assert property (@(posedge clk) disable iff (reset)
        issue |=> ##[1:mul_latency] (wakeup && state == ex_busy));

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load,
    input  ooo_pkg::alu_func_e                 func,
    input  logic [ooo_pkg::rob_tag_len-1:0]    t1, t2, dst,
    input  logic                               ready1, ready2,
    input  logic [ooo_pkg::xlen-1:0]           v1, v2,
    input  logic                               issue,
    input  logic                               wakeup,
    input  logic [ooo_pkg::rob_tag_len-1:0]    wakeup_tag,
    input  logic [ooo_pkg::xlen-1:0]           wakeup_value,
    output logic                               insn_ready,
    output logic                               is_full,
    output ooo_pkg::alu_func_e                 func_out,
    output logic [ooo_pkg::xlen-1:0]           v1_out, v2_out,
    output logic [ooo_pkg::rob_tag_len-1:0]    dst_tag
);
    import ooo_pkg::*;

    // entry fields, only the valid bits are control state
    alu_func_e              e_func  [rs_entries];
    logic [rob_tag_len-1:0] e_t1    [rs_entries];
    logic [rob_tag_len-1:0] e_t2    [rs_entries];
    logic [rob_tag_len-1:0] e_dst   [rs_entries];
    logic                   e_rdy1  [rs_entries];
    logic                   e_rdy2  [rs_entries];
    logic [xlen-1:0]        e_v1    [rs_entries];
    logic [xlen-1:0]        e_v2    [rs_entries];
    logic [rs_idx_len-1:0]  e_age   [rs_entries]; // 0 is the oldest entry
    logic [rs_entries-1:0]  e_valid;

    logic [rs_entries-1:0] hit1, hit2;   // operand produced by the broadcast of this cycle
    logic [rs_entries-1:0] ready_flags;
    logic [rs_idx_len:0]   num_valid;
    logic [rs_idx_len-1:0] sel_idx, sel_age, free_idx, new_age;
    logic                  in_hit1, in_hit2;
    logic                  age_clash;

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            hit1[i] = wakeup && !e_rdy1[i] && (e_t1[i] == wakeup_tag);
            hit2[i] = wakeup && !e_rdy2[i] && (e_t2[i] == wakeup_tag);
            // same-cycle wakeup counts, so a dependent can issue alongside its producer's result
            ready_flags[i] = e_valid[i] && (e_rdy1[i] || hit1[i]) && (e_rdy2[i] || hit2[i]);
        end
    end

    assign insn_ready = |ready_flags;

    always_comb begin
        num_valid = '0;
        for (int i = 0; i < rs_entries; i++) begin
            num_valid = num_valid + e_valid[i];
        end
    end

    assign is_full = (num_valid == (rs_idx_len + 1)'(rs_entries));

    // oldest ready entry, ages are unique so ties never happen
    always_comb begin
        sel_idx = '0;
        sel_age = '1;
        for (int i = 0; i < rs_entries; i++) begin
            if (ready_flags[i] && e_age[i] <= sel_age) begin
                sel_idx = rs_idx_len'(i);
                sel_age = e_age[i];
            end
        end
    end

    // lowest free slot, downward scan so the last hit wins
    always_comb begin
        free_idx = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (!e_valid[i]) free_idx = rs_idx_len'(i);
        end
    end

    // the newcomer is youngest, one place earlier if an entry leaves this cycle
    assign new_age = rs_idx_len'(num_valid - issue);
    assign in_hit1 = wakeup && !ready1 && (t1 == wakeup_tag);
    assign in_hit2 = wakeup && !ready2 && (t2 == wakeup_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid <= '0;
        end else begin
            if (issue) e_valid[sel_idx] <= 1'b0;
            if (load)  e_valid[free_idx] <= 1'b1; // the free slot is never the issued one
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_entries; i++) begin
            if (hit1[i]) begin
                e_rdy1[i] <= 1'b1;
                e_v1[i]   <= wakeup_value;
            end
            if (hit2[i]) begin
                e_rdy2[i] <= 1'b1;
                e_v2[i]   <= wakeup_value;
            end
            if (issue && e_valid[i] && e_age[i] > sel_age) begin
                e_age[i] <= e_age[i] - 1'b1; // close the gap left by the issued entry
            end
        end
        if (issue) begin
            // registered issue outputs, forwarding a value that arrives in the issue cycle
            func_out <= e_func[sel_idx];
            v1_out   <= hit1[sel_idx] ? wakeup_value : e_v1[sel_idx];
            v2_out   <= hit2[sel_idx] ? wakeup_value : e_v2[sel_idx];
            dst_tag  <= e_dst[sel_idx];
        end
        if (load) begin
            e_func[free_idx] <= func;
            e_t1[free_idx]   <= t1;
            e_t2[free_idx]   <= t2;
            e_dst[free_idx]  <= dst;
            e_rdy1[free_idx] <= ready1 || in_hit1;
            e_rdy2[free_idx] <= ready2 || in_hit2;
            e_v1[free_idx]   <= in_hit1 ? wakeup_value : v1;
            e_v2[free_idx]   <= in_hit2 ? wakeup_value : v2;
            e_age[free_idx]  <= new_age;
        end
    end

    // two valid entries sharing an age would break oldest-first selection
    always_comb begin
        age_clash = 1'b0;
        for (int i = 0; i < rs_entries; i++) begin
            for (int j = i + 1; j < rs_entries; j++) begin
                if (e_valid[i] && e_valid[j] && e_age[i] == e_age[j]) age_clash = 1'b1;
            end
        end
    end

    // the dispatch buffer holds back while the station is full
    a_no_load_when_full: assert property (@(posedge clk) disable iff (reset) load |-> !is_full);

    // the execution unit only issues when something is ready
    a_issue_needs_ready: assert property (@(posedge clk) disable iff (reset)
        issue |-> insn_ready);

    a_unique_ages: assert property (@(posedge clk) disable iff (reset) !age_clash);

endmodule

// ==== hw/dispatch_buffer.sv ====
`timescale 1ns/1ps

module dispatch_buffer (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load,
    input  ooo_pkg::alu_func_e                 func,
    input  logic [ooo_pkg::rob_tag_len-1:0]    t1, t2, dst,
    input  logic                               ready1, ready2,
    input  logic [ooo_pkg::xlen-1:0]           v1, v2,
    input  logic                               wakeup,
    input  logic [ooo_pkg::rob_tag_len-1:0]    wakeup_tag,
    input  logic [ooo_pkg::xlen-1:0]           wakeup_value,
    input  logic                               rs_full,
    output logic                               full,
    output logic                               rs_load,
    output ooo_pkg::alu_func_e                 rs_func,
    output logic [ooo_pkg::rob_tag_len-1:0]    rs_t1, rs_t2, rs_dst,
    output logic                               rs_ready1, rs_ready2,
    output logic [ooo_pkg::xlen-1:0]           rs_v1, rs_v2
);
    import ooo_pkg::*;

    // slot storage for the queued instructions
    alu_func_e              q_func  [db_entries];
    logic [rob_tag_len-1:0] q_t1    [db_entries];
    logic [rob_tag_len-1:0] q_t2    [db_entries];
    logic [rob_tag_len-1:0] q_dst   [db_entries];
    logic                   q_rdy1  [db_entries];
    logic                   q_rdy2  [db_entries];
    logic [xlen-1:0]        q_v1    [db_entries];
    logic [xlen-1:0]        q_v2    [db_entries];

    logic [db_idx_len-1:0] wr_ptr, rd_ptr;
    logic [db_idx_len:0]   count;  // 0 to db_entries
    logic                  empty, bypass, push, pop;
    logic                  in_hit1, in_hit2;

    assign empty = (count == '0);
    assign full  = (count == (db_idx_len + 1)'(db_entries));

    // an empty buffer hands a new instruction straight to the station and saves a cycle
    assign bypass  = empty && load && !rs_full;
    assign pop     = !empty && !rs_full;
    assign push    = load && !full && !bypass; // a load while full is dropped
    assign rs_load = pop || bypass;

    // the head slot or the incoming instruction when it bypasses
    assign rs_func   = empty ? func   : q_func[rd_ptr];
    assign rs_t1     = empty ? t1     : q_t1[rd_ptr];
    assign rs_t2     = empty ? t2     : q_t2[rd_ptr];
    assign rs_dst    = empty ? dst    : q_dst[rd_ptr];
    assign rs_ready1 = empty ? ready1 : q_rdy1[rd_ptr];
    assign rs_ready2 = empty ? ready2 : q_rdy2[rd_ptr];
    assign rs_v1     = empty ? v1     : q_v1[rd_ptr];
    assign rs_v2     = empty ? v2     : q_v2[rd_ptr];

    // a pending operand whose producer broadcasts right now is captured on the way in
    assign in_hit1 = wakeup && !ready1 && (t1 == wakeup_tag);
    assign in_hit2 = wakeup && !ready2 && (t2 == wakeup_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // snoop the broadcast so waiting instructions do not miss their producer
        // free slots may match as well and are overwritten on push
        for (int i = 0; i < db_entries; i++) begin
            if (wakeup && !q_rdy1[i] && q_t1[i] == wakeup_tag) begin
                q_rdy1[i] <= 1'b1;
                q_v1[i]   <= wakeup_value;
            end
            if (wakeup && !q_rdy2[i] && q_t2[i] == wakeup_tag) begin
                q_rdy2[i] <= 1'b1;
                q_v2[i]   <= wakeup_value;
            end
        end
        if (push) begin // comes after the snoop loop so the new slot wins
            q_func[wr_ptr] <= func;
            q_t1[wr_ptr]   <= t1;
            q_t2[wr_ptr]   <= t2;
            q_dst[wr_ptr]  <= dst;
            q_rdy1[wr_ptr] <= ready1 || in_hit1;
            q_rdy2[wr_ptr] <= ready2 || in_hit2;
            q_v1[wr_ptr]   <= in_hit1 ? wakeup_value : v1;
            q_v2[wr_ptr]   <= in_hit2 ? wakeup_value : v2;
        end
    end

endmodule

// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    // datapath and tag widths
    localparam int xlen        = 32;
    localparam int rob_tag_len = 4;  // 16 tags, the source never reuses one while it is in flight

    // reservation station sizing, an age fits in rs_idx_len bits
    localparam int rs_entries = 4;
    localparam int rs_idx_len = 2;

    // dispatch buffer sizing, the depth is a power of two so the pointers wrap on their own
    localparam int db_entries = 4;
    localparam int db_idx_len = 2;

    // integer functions handled by the single execution unit
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_mul
    } alu_func_e;

    // execute cycles of a multiply, all other functions take a single cycle
    localparam int mul_latency = 3;
    localparam int ex_cnt_len  = $clog2(mul_latency); // width of the latency countdown

    // execution unit FSM
    typedef enum logic {
        ex_idle,
        ex_busy
    } ex_state_e;

endpackage
